//--- dcache_top.f
+incdir+verilog
verilog/axi_burst_pkg.sv
verilog/dcache_pkg.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_burst.sv
verilog/dcache_top.sv
test/dcache_asserts.sv
test/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f dcache_top.f --top-module dcache_tb \
    -o Vdcache_tb || { echo "Build error"; exit 1; }
./obj_dir/Vdcache_tb > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

//--- test/dcache_asserts.sv
// Bus handshake and stall checks that the testbench binds into the cache top level

`timescale 1ns/10ps

`include "dcache_params.svh"

module dcache_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    stall,
    input axi_burst_pkg::mem_out_t mem_out,
    input axi_burst_pkg::mem_in_t  mem_in
);

    // Accepted W beats of the current write-back
    int w_count;

    // Failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n || (mem_out.aw.valid && mem_in.awready)) begin
            w_count <= 0;
        end else if (mem_out.w.valid && mem_in.wready) begin
            w_count <= w_count + 1;
        end
    end

    // ----------------------------------------
    // Valid holds until ready
    // ----------------------------------------

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_out.ar.valid && !mem_in.arready |=> mem_out.ar.valid && $stable(mem_out.ar.addr))
        else begin
            fail_count++;
            $error("AR dropped before arready");
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_out.aw.valid && !mem_in.awready |=> mem_out.aw.valid && $stable(mem_out.aw.addr))
        else begin
            fail_count++;
            $error("AW dropped before awready");
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_out.w.valid && !mem_in.wready |=> mem_out.w.valid && $stable(mem_out.w.data))
        else begin
            fail_count++;
            $error("W beat dropped before wready");
        end

    // Last only on beat 128
    a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
        mem_out.w.valid |-> (mem_out.w.last == (w_count == `DCACHE_WORDS - 1)))
        else begin
            fail_count++;
            $error("W last on the wrong beat");
        end

    // Quiet bus right after reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !stall && !mem_out.ar.valid && !mem_out.aw.valid
            && !mem_out.w.valid && !mem_out.rready && !mem_out.bready)
        else begin
            fail_count++;
            $error("Bus or stall active after reset");
        end

endmodule

//--- test/dcache_stim.txt
// Columns: op (1 read, 2 write, 3 flush), address, write data, byte enables, expected read data
// Memory words start as word address XOR 5a000000
1 00001000 00000000 0 5a000400
1 00001004 00000000 0 5a000401
1 000011fc 00000000 0 5a00047f
2 00001008 aabbccdd 3 00000000
1 00001008 00000000 0 5a00ccdd
2 00001010 11223344 c 00000000
1 00001010 00000000 0 11220404
1 00002000 00000000 0 5a000800
1 00001008 00000000 0 5a00ccdd
2 00001100 deadbeef f 00000000
3 00000000 00000000 0 00000000
1 00003004 00000000 0 5a000c01
1 00001100 00000000 0 deadbeef
2 00001104 00000077 1 00000000
1 00001104 00000000 0 5a000477
3 00000000 00000000 0 00000000
3 00000000 00000000 0 00000000
1 000011fc 00000000 0 5a00047f

//--- test/dcache_tb.sv
// Testbench for the data cache that runs the stimulus file against a burst memory model

`timescale 1ns/10ps

`include "dcache_params.svh"

module dcache_tb;

    localparam int          MAX_OPS  = 64;
    localparam logic [31:0] PATTERN  = 32'h5a00_0000;
    localparam logic [31:0] OP_READ  = 32'd1;
    localparam logic [31:0] OP_WRITE = 32'd2;
    localparam logic [31:0] OP_FLUSH = 32'd3;
    localparam int          LOW_W    = `DCACHE_AW - `DCACHE_TAG_W;
    // Worst case per line is two bursts at heavy back-pressure
    localparam int          OP_CYCLES = 2 * (`DCACHE_WORDS + 4) * 16;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    dcache_pkg::cpu_req_t    req;
    axi_burst_pkg::mem_in_t  mem_in;
    axi_burst_pkg::mem_out_t mem_out;
    logic [`DCACHE_DW-1:0]   read_data;
    logic                    stall;

    logic [31:0] stim [5*MAX_OPS];
    int          n_ops;
    logic [31:0] lfsr_state;

    // Memory contents and expected coherent view by word address
    logic [31:0] mem_words [int unsigned];
    logic [31:0] shadow [int unsigned];

    // Memory model state
    logic        rd_active;
    logic [31:0] rd_addr;
    int          rd_beat;
    logic        wr_active;
    logic [31:0] wr_addr;
    int          wr_beat;
    logic        b_pending;
    int          wb_count;
    int          fill_count;

    // Expected cache state
    logic                     res_valid;
    logic                     res_dirty;
    logic [`DCACHE_TAG_W-1:0] res_block;
    logic                     wb_allowed;
    logic                     fill_allowed;
    logic [31:0]              exp_wb_addr;
    logic [31:0]              exp_fill_addr;

    dcache_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .flush     (flush),
        .mem_in    (mem_in),
        .read_data (read_data),
        .stall     (stall),
        .mem_out   (mem_out)
    );

    bind dcache_top dcache_asserts u_asserts (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .mem_out (mem_out),
        .mem_in  (mem_in)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers and compare tasks
    // ----------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem_words.exists(addr >> 2)) begin
            return mem_words[addr >> 2];
        end
        return (addr >> 2) ^ PATTERN;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr >> 2)) begin
            return shadow[addr >> 2];
        end
        return (addr >> 2) ^ PATTERN;
    endfunction

    task automatic check_read(input logic [`DCACHE_DW-1:0] got, input logic [`DCACHE_DW-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED read_data: expected %h, got %h", exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic check_wbeat(input axi_burst_pkg::wbeat_t got, input axi_burst_pkg::wbeat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED mem_out.w: expected %h, got %h", exp, got));
        end
    endtask

    task automatic check_addr(input string name, input axi_burst_pkg::addr_chan_t got,
                              input axi_burst_pkg::addr_chan_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: expected %h, got %h", name, exp, got));
        end
    endtask

    // ----------------------------------------
    // Burst memory model
    // ----------------------------------------

    // Handshakes seen at the rising edge
    always @(posedge clk) begin
        axi_burst_pkg::addr_chan_t exp_chan;
        axi_burst_pkg::wbeat_t     exp_beat;
        logic [31:0]               waddr;
        if (rst_n) begin
            // Read and response ready follow the model's view of the burst
            check_bit("mem_out.rready", mem_out.rready, rd_active);
            check_bit("mem_out.bready", mem_out.bready, b_pending);
            if (mem_out.ar.valid && mem_in.arready) begin
                if (!fill_allowed || wb_allowed) begin
                    abort_run("Refill started when no refill was due");
                end
                exp_chan.valid = 1'b1;
                exp_chan.addr  = exp_fill_addr;
                check_addr("mem_out.ar", mem_out.ar, exp_chan);
                fill_allowed = 1'b0;
                rd_active    = 1'b1;
                rd_addr      = mem_out.ar.addr;
                rd_beat      = 0;
            end
            if (mem_in.r.valid && mem_out.rready) begin
                rd_beat++;
                if (mem_in.r.last) begin
                    rd_active = 1'b0;
                    fill_count++;
                end
            end
            if (mem_out.aw.valid && mem_in.awready) begin
                if (!wb_allowed) begin
                    abort_run("Write-back started from a clean block");
                end
                exp_chan.valid = 1'b1;
                exp_chan.addr  = exp_wb_addr;
                check_addr("mem_out.aw", mem_out.aw, exp_chan);
                wb_allowed = 1'b0;
                wr_active  = 1'b1;
                wr_addr    = mem_out.aw.addr;
                wr_beat    = 0;
            end
            if (mem_out.w.valid && mem_in.wready) begin
                waddr          = wr_addr + 32'(4 * wr_beat);
                exp_beat.valid = 1'b1;
                exp_beat.data  = shadow_word(waddr);
                exp_beat.last  = (wr_beat == `DCACHE_WORDS - 1);
                check_wbeat(mem_out.w, exp_beat);
                mem_words[waddr >> 2] = mem_out.w.data;
                if (exp_beat.last) begin
                    b_pending = 1'b1;
                end
                wr_beat++;
            end
            if (mem_in.bvalid && mem_out.bready) begin
                b_pending = 1'b0;
                wr_active = 1'b0;
                wb_count++;
            end
        end
    end

    // Readies and beats change on the falling edge with one LFSR bit per ready
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            mem_in = '0;
        end else begin
            mem_in.arready = next_rand_bit();
            mem_in.awready = next_rand_bit();
            mem_in.wready  = wr_active && !b_pending && next_rand_bit();
            mem_in.r.valid = rd_active && next_rand_bit();
            mem_in.r.data  = mem_word(rd_addr + 32'(4 * rd_beat));
            mem_in.r.last  = (rd_beat == `DCACHE_WORDS - 1);
            mem_in.bvalid  = b_pending && next_rand_bit();
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    // Leaves at a rising edge where stall is low
    task automatic wait_not_stalled(input logic exp_stall);
        @(posedge clk);
        check_bit("stall", stall, exp_stall);
        while (stall === 1'b1) begin
            @(posedge clk);
        end
    endtask

    task automatic run_op(input logic [31:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] be,
                          input logic [31:0] expv);
        logic [`DCACHE_TAG_W-1:0] block;
        logic                     is_miss;
        logic                     need_wb;
        int                       wb_before;
        int                       fill_before;
        logic [31:0]              bits;
        block       = addr[`DCACHE_AW-1 -: `DCACHE_TAG_W];
        wb_before   = wb_count;
        fill_before = fill_count;
        exp_wb_addr = {res_block, LOW_W'(0)};
        if (op == OP_FLUSH) begin
            is_miss    = 1'b0;
            need_wb    = res_dirty;
            wb_allowed = res_dirty;
            req        = '0;
            flush      = 1'b1;
            wait_not_stalled(need_wb);
            flush = 1'b0;
        end else begin
            is_miss       = !res_valid || (block != res_block);
            need_wb       = is_miss && res_dirty;
            wb_allowed    = need_wb;
            fill_allowed  = is_miss;
            exp_fill_addr = {block, LOW_W'(0)};
            req.addr      = addr;
            req.wdata     = wdata;
            req.rd_en     = (op == OP_READ);
            req.wr_en     = (op == OP_WRITE);
            req.byte_en   = be[3:0];
            wait_not_stalled(is_miss);
            if (op == OP_READ) begin
                check_read(read_data, expv);
            end
        end
        @(negedge clk);
        req   = '0;
        flush = 1'b0;
        if (wb_count != wb_before + (need_wb ? 1 : 0)) begin
            abort_run("Number of write-backs is wrong");
        end
        if (fill_count != fill_before + (is_miss ? 1 : 0)) begin
            abort_run("Number of refills is wrong");
        end
        // Track what the cache should now hold
        if (op == OP_FLUSH) begin
            res_dirty = 1'b0;
        end else if (is_miss) begin
            res_valid = 1'b1;
            res_block = block;
            res_dirty = 1'b0;
        end
        if (op == OP_WRITE && be[3:0] != 4'h0) begin
            for (int i = 0; i < 4; i++) begin
                bits[8*i +: 8] = {8{be[i]}};
            end
            shadow[addr >> 2] = (shadow_word(addr) & ~bits) | (wdata & bits);
            res_dirty = 1'b1;
        end
    endtask

    // Watchdog sized from the stimulus length
    initial begin
        wait (n_ops > 0);
        repeat (n_ops * OP_CYCLES + 100) @(posedge clk);
        abort_run("Timed out waiting for the cache to finish");
    end

    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        req          = '0;
        mem_in       = '0;
        lfsr_state   = 32'he9a5_4281;
        rd_active    = 1'b0;
        rd_addr      = '0;
        rd_beat      = 0;
        wr_active    = 1'b0;
        wr_addr      = '0;
        wr_beat      = 0;
        b_pending    = 1'b0;
        wb_count     = 0;
        fill_count   = 0;
        res_valid    = 1'b0;
        res_dirty    = 1'b0;
        res_block    = '0;
        wb_allowed   = 1'b0;
        fill_allowed = 1'b0;
        n_ops        = 0;
        foreach (stim[k]) begin
            stim[k] = '0;
        end
        $readmemh("test/dcache_stim.txt", stim);
        // A zero op code ends the list
        while (n_ops < MAX_OPS && stim[5*n_ops] != 32'd0) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            abort_run("Stimulus file holds no operations");
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < n_ops; i++) begin
            run_op(stim[5*i], stim[5*i+1], stim[5*i+2], stim[5*i+3], stim[5*i+4]);
        end
        // Bound assertions count their own failures
        if (u_dut.u_asserts.fail_count != 0) begin
            abort_run("A bound bus assertion failed during the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- verilog/axi_burst_pkg.sv
// Channel structs of the AXI-style burst bus between the cache and main memory

`include "dcache_params.svh"

package axi_burst_pkg;

    // Address channel shared by AR and AW
    // Address is always block aligned
    typedef struct packed {
        logic                  valid;
        logic [`DCACHE_AW-1:0] addr;
    } addr_chan_t;

    // Write data beat
    typedef struct packed {
        logic                  valid;
        logic [`DCACHE_DW-1:0] data;
        logic                  last;
    } wbeat_t;

    // Read data beat
    typedef struct packed {
        logic                  valid;
        logic [`DCACHE_DW-1:0] data;
        logic                  last;
    } rbeat_t;

    // Everything the cache drives
    typedef struct packed {
        addr_chan_t ar;
        addr_chan_t aw;
        wbeat_t     w;
        logic       rready;
        logic       bready;
    } mem_out_t;

    // Everything the memory drives
    typedef struct packed {
        logic   arready;
        logic   awready;
        logic   wready;
        rbeat_t r;
        logic   bvalid;
    } mem_in_t;

endpackage

//--- verilog/dcache_burst.sv
// Burst engine that moves one whole block to or from memory per start pulse

`timescale 1ns/10ps

`include "dcache_params.svh"

module dcache_burst (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_wb,
    input  logic                     start_fill,
    input  logic [`DCACHE_AW-1:0]    burst_addr,
    input  logic [`DCACHE_DW-1:0]    beat_data,
    input  axi_burst_pkg::mem_in_t   mem_in,
    output axi_burst_pkg::mem_out_t  mem_out,
    output logic [`DCACHE_IDX_W-1:0] beat_index,
    output logic                     fill_en,
    output logic [`DCACHE_DW-1:0]    fill_data,
    output logic                     done,
    output logic                     fill_done
);

    dcache_pkg::cache_state_t state, next_state;

    // Block address of the burst in flight
    logic [`DCACHE_AW-1:0] addr_q;

    // Beat counter for both directions
    logic [`DCACHE_IDX_W-1:0] beat_q;
    logic                     last_beat;
    logic                     w_fire;
    logic                     r_fire;

    assign last_beat = (beat_q == `DCACHE_IDX_W'(`DCACHE_WORDS - 1));
    assign w_fire    = (state == dcache_pkg::WB_DATA) && mem_in.wready;
    assign r_fire    = (state == dcache_pkg::FILL_DATA) && mem_in.r.valid;

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------

    always_comb begin
        next_state = state;
        done       = 1'b0;

        case (state)
            dcache_pkg::WB_ADDR: begin
                if (mem_in.awready) begin
                    next_state = dcache_pkg::WB_DATA;
                end
            end
            dcache_pkg::WB_DATA: begin
                if (w_fire && last_beat) begin
                    next_state = dcache_pkg::WB_RESP;
                end
            end
            dcache_pkg::WB_RESP: begin
                // Response code is not checked
                if (mem_in.bvalid) begin
                    done       = 1'b1;
                    next_state = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::FILL_ADDR: begin
                if (mem_in.arready) begin
                    next_state = dcache_pkg::FILL_DATA;
                end
            end
            dcache_pkg::FILL_DATA: begin
                if (r_fire && mem_in.r.last) begin
                    done       = 1'b1;
                    next_state = dcache_pkg::IDLE;
                end
            end
            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase

        // A start can arrive in the last cycle of the previous burst
        if (next_state == dcache_pkg::IDLE) begin
            if (start_wb) begin
                next_state = dcache_pkg::WB_ADDR;
            end else if (start_fill) begin
                next_state = dcache_pkg::FILL_ADDR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= dcache_pkg::IDLE;
            beat_q <= '0;
        end else begin
            state <= next_state;
            if (state == dcache_pkg::WB_ADDR || state == dcache_pkg::FILL_ADDR) begin
                beat_q <= '0;
            end else if (w_fire || r_fire) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // Address captured with the start pulse
    always_ff @(posedge clk) begin
        if (start_wb || start_fill) begin
            addr_q <= burst_addr;
        end
    end

    // ----------------------------------------
    // Bus and store side
    // ----------------------------------------

    always_comb begin
        mem_out          = '0;
        mem_out.ar.valid = (state == dcache_pkg::FILL_ADDR);
        mem_out.ar.addr  = addr_q;
        mem_out.aw.valid = (state == dcache_pkg::WB_ADDR);
        mem_out.aw.addr  = addr_q;
        mem_out.w.valid  = (state == dcache_pkg::WB_DATA);
        mem_out.w.data   = beat_data;
        mem_out.w.last   = (state == dcache_pkg::WB_DATA) && last_beat;
        mem_out.rready   = (state == dcache_pkg::FILL_DATA);
        mem_out.bready   = (state == dcache_pkg::WB_RESP);
    end

    assign beat_index = beat_q;
    assign fill_en    = r_fire;
    assign fill_data  = mem_in.r.data;
    assign fill_done  = r_fire && mem_in.r.last;

endmodule

//--- verilog/dcache_ctrl.sv
// Hit check and miss, write-back and flush sequencing of the data cache

`timescale 1ns/10ps

`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dcache_pkg::cpu_req_t     req,
    input  logic                     flush,
    input  logic [`DCACHE_TAG_W-1:0] tag,
    input  logic                     valid,
    input  logic                     dirty,
    input  logic                     done,
    output logic                     stall,
    output logic                     store_wr_en,
    output logic                     start_wb,
    output logic                     start_fill,
    output logic [`DCACHE_AW-1:0]    burst_addr,
    output logic                     clean,
    output logic [`DCACHE_TAG_W-1:0] fill_tag
);

    // Controller only tracks which burst is outstanding
    // WB_DATA stands for a running write-back and FILL_DATA for a running refill
    dcache_pkg::cache_state_t state, next_state;

    // Set while the running write-back came from a flush strobe
    logic flushing, next_flushing;

    dcache_pkg::addr_split_t req_split;
    dcache_pkg::addr_split_t wb_split;
    dcache_pkg::addr_split_t fill_split;
    logic                    wr_req;
    logic                    hit;
    logic                    miss;
    logic                    flush_req;
    logic                    use_wb_addr;

    // ----------------------------------------
    // Request decode
    // ----------------------------------------

    assign req_split = req.addr;

    // A write with no byte enabled is no access
    assign wr_req = req.wr_en && (|req.byte_en);

    assign hit  = valid && (req_split.tag == tag);
    assign miss = (req.rd_en || wr_req) && !hit;

    // Nothing to write back from a clean block
    assign flush_req = flush && dirty;

    // Block aligned burst addresses
    always_comb begin
        wb_split        = '0;
        wb_split.tag    = tag;
        fill_split      = '0;
        fill_split.tag  = req_split.tag;
    end

    assign burst_addr = use_wb_addr ? wb_split : fill_split;
    assign fill_tag   = req_split.tag;

    // Merge only while idle and no flush is pending
    assign store_wr_en = (state == dcache_pkg::IDLE) && hit && wr_req && !flush_req;

    assign stall = (state != dcache_pkg::IDLE) || miss || flush_req;

    // ----------------------------------------
    // Sequencing FSM
    // ----------------------------------------

    always_comb begin
        next_state    = state;
        next_flushing = flushing;
        start_wb      = 1'b0;
        start_fill    = 1'b0;
        use_wb_addr   = 1'b0;
        clean         = 1'b0;

        case (state)
            dcache_pkg::IDLE: begin
                if (flush_req) begin
                    start_wb      = 1'b1;
                    use_wb_addr   = 1'b1;
                    next_flushing = 1'b1;
                    next_state    = dcache_pkg::WB_DATA;
                end else if (miss && dirty) begin
                    // Old block goes back to memory first
                    start_wb    = 1'b1;
                    use_wb_addr = 1'b1;
                    next_state  = dcache_pkg::WB_DATA;
                end else if (miss) begin
                    start_fill = 1'b1;
                    next_state = dcache_pkg::FILL_DATA;
                end
            end

            dcache_pkg::WB_DATA: begin
                if (done) begin
                    clean = 1'b1;
                    if (flushing) begin
                        next_flushing = 1'b0;
                        next_state    = dcache_pkg::IDLE;
                    end else begin
                        // Refill starts right behind the write-back
                        start_fill = 1'b1;
                        next_state = dcache_pkg::FILL_DATA;
                    end
                end
            end

            dcache_pkg::FILL_DATA: begin
                if (done) begin
                    next_state = dcache_pkg::IDLE;
                end
            end

            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= dcache_pkg::IDLE;
            flushing <= 1'b0;
        end else begin
            state    <= next_state;
            flushing <= next_flushing;
        end
    end

endmodule

//--- verilog/dcache_params.svh
// Cache geometry and bus widths included by every package and module that sizes a signal

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Words held by the single resident block
`define DCACHE_WORDS 128

// Word index inside the block from address bits 8:2
`define DCACHE_IDX_W 7

// Byte offset inside a word
`define DCACHE_OFF_W 2

// Address and data widths of the core and the burst bus
`define DCACHE_AW 32
`define DCACHE_DW 32

// Tag is what is left above index and offset in address bits 31:9
`define DCACHE_TAG_W (`DCACHE_AW - `DCACHE_IDX_W - `DCACHE_OFF_W)

// Bursts are INCR with 4-byte beats and ID 0
// Every burst moves DCACHE_WORDS beats

`endif

//--- verilog/dcache_pkg.sv
// CPU request, address split and FSM state types of the data cache

`include "dcache_params.svh"

package dcache_pkg;

    // Request from the core
    // Held as a level while stall is high
    typedef struct packed {
        logic [`DCACHE_AW-1:0] addr;
        logic [`DCACHE_DW-1:0] wdata;
        logic                  rd_en;
        logic                  wr_en;
        logic [3:0]            byte_en;
    } cpu_req_t;

    // Address fields seen by a direct-mapped single block
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0] tag;
        logic [`DCACHE_IDX_W-1:0] index;
        logic [`DCACHE_OFF_W-1:0] offset;
    } addr_split_t;

    // Write-back states first, then refill states
    typedef enum logic [2:0] {
        IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA
    } cache_state_t;

endpackage

//--- verilog/dcache_store.sv
// Block storage of the data cache with tag and flags that the core and refills write

`timescale 1ns/10ps

`include "dcache_params.svh"

module dcache_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`DCACHE_IDX_W-1:0] rd_index,
    input  logic                     wr_en,
    input  logic [`DCACHE_IDX_W-1:0] wr_index,
    input  logic [`DCACHE_DW-1:0]    wr_data,
    input  logic [3:0]               wr_mask,
    input  logic                     fill_en,
    input  logic [`DCACHE_IDX_W-1:0] fill_index,
    input  logic [`DCACHE_DW-1:0]    fill_data,
    input  logic                     fill_done,
    input  logic [`DCACHE_TAG_W-1:0] fill_tag,
    input  logic                     clean,
    input  logic [`DCACHE_IDX_W-1:0] beat_index,
    output logic [`DCACHE_DW-1:0]    rd_data,
    output logic [`DCACHE_DW-1:0]    beat_data,
    output logic [`DCACHE_TAG_W-1:0] tag,
    output logic                     valid,
    output logic                     dirty
);

    // Block words
    logic [`DCACHE_DW-1:0] mem [`DCACHE_WORDS];

    // Byte enables widened to a bit mask
    logic [`DCACHE_DW-1:0] wr_bits;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wr_bits[8*i +: 8] = {8{wr_mask[i]}};
        end
    end

    // ----------------------------------------
    // Data array
    // ----------------------------------------

    // Core writes and refill beats never overlap
    // Core writes only happen while the controller is idle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= (mem[wr_index] & ~wr_bits) | (wr_data & wr_bits);
        end else if (fill_en) begin
            mem[fill_index] <= fill_data;
        end
    end

    // Hit read port and write-back beat port
    assign rd_data   = mem[rd_index];
    assign beat_data = mem[beat_index];

    // ----------------------------------------
    // Tag and flags
    // ----------------------------------------

    // New tag lands with the last refill beat
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            if (fill_done) begin
                // Fresh copy of memory
                valid <= 1'b1;
                dirty <= 1'b0;
            end else if (clean) begin
                // Memory now matches the block
                dirty <= 1'b0;
            end else if (wr_en) begin
                dirty <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/dcache_top.sv
// Data cache top level that joins block storage, controller and burst engine

`timescale 1ns/10ps

`include "dcache_params.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dcache_pkg::cpu_req_t    req,
    input  logic                    flush,
    input  axi_burst_pkg::mem_in_t  mem_in,
    output logic [`DCACHE_DW-1:0]   read_data,
    output logic                    stall,
    output axi_burst_pkg::mem_out_t mem_out
);

    // Store to controller
    logic [`DCACHE_TAG_W-1:0] tag;
    logic                     valid;
    logic                     dirty;

    // Controller outputs
    logic                     store_wr_en;
    logic                     start_wb;
    logic                     start_fill;
    logic [`DCACHE_AW-1:0]    burst_addr;
    logic                     clean;
    logic [`DCACHE_TAG_W-1:0] fill_tag;

    // Burst engine to store
    logic [`DCACHE_IDX_W-1:0] beat_index;
    logic [`DCACHE_DW-1:0]    beat_data;
    logic                     fill_en;
    logic [`DCACHE_DW-1:0]    fill_data;
    logic                     fill_done;
    logic                     done;

    // Word index is address bits 8:2
    dcache_store u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index   (req.addr[`DCACHE_IDX_W+`DCACHE_OFF_W-1:`DCACHE_OFF_W]),
        .wr_en      (store_wr_en),
        .wr_index   (req.addr[`DCACHE_IDX_W+`DCACHE_OFF_W-1:`DCACHE_OFF_W]),
        .wr_data    (req.wdata),
        .wr_mask    (req.byte_en),
        .fill_en    (fill_en),
        .fill_index (beat_index),
        .fill_data  (fill_data),
        .fill_done  (fill_done),
        .fill_tag   (fill_tag),
        .clean      (clean),
        .beat_index (beat_index),
        .rd_data    (read_data),
        .beat_data  (beat_data),
        .tag        (tag),
        .valid      (valid),
        .dirty      (dirty)
    );

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .flush       (flush),
        .tag         (tag),
        .valid       (valid),
        .dirty       (dirty),
        .done        (done),
        .stall       (stall),
        .store_wr_en (store_wr_en),
        .start_wb    (start_wb),
        .start_fill  (start_fill),
        .burst_addr  (burst_addr),
        .clean       (clean),
        .fill_tag    (fill_tag)
    );

    dcache_burst u_burst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_wb   (start_wb),
        .start_fill (start_fill),
        .burst_addr (burst_addr),
        .beat_data  (beat_data),
        .mem_in     (mem_in),
        .mem_out    (mem_out),
        .beat_index (beat_index),
        .fill_en    (fill_en),
        .fill_data  (fill_data),
        .done       (done),
        .fill_done  (fill_done)
    );

endmodule
